/* list.f */
+incdir+rtl
+incdir+verif
rtl/eval_pkg.sv
rtl/material_sum.sv
rtl/material_guard.sv
rtl/mobility_score.sv
rtl/eval_sequencer.sv
rtl/eval_top.sv
verif/tb_clock.sv
verif/eval_tb.sv

/* rtl/eval_config.svh */
`ifndef EVAL_CONFIG_SVH
`define EVAL_CONFIG_SVH

// board geometry
`define SQUARES      64
`define RANKS        8
`define FILES        8
`define PIECE_WIDTH  4
`define BOARD_WIDTH  256 // SQUARES * PIECE_WIDTH

`define POP_WIDTH    6
`define SCORE_WIDTH  22
`define TALLY_WIDTH  9

// 7, 8 and 15 are unused piece codes
`define EMPTY_POSN   4'd0
`define WHITE_PAWN   4'd1
`define WHITE_KNIT   4'd2
`define WHITE_BISH   4'd3
`define WHITE_ROOK   4'd4
`define WHITE_QUEN   4'd5
`define WHITE_KING   4'd6
`define BLACK_PAWN   4'd9
`define BLACK_KNIT   4'd10
`define BLACK_BISH   4'd11
`define BLACK_ROOK   4'd12
`define BLACK_QUEN   4'd13
`define BLACK_KING   4'd14

// centipawn values
`define VALUE_PAWN   100
`define VALUE_KNIT   310
`define VALUE_BISH   320
`define VALUE_ROOK   500
`define VALUE_QUEN   900
`define VALUE_KING   20000

`define POP_WEIGHT   10
`define BUSY_CYCLES  4 // cycles the sequencer waits for the pipelines

`endif

/* rtl/eval_pkg.sv */
`default_nettype none

`include "eval_config.svh"

package eval_pkg;

   // one square of the board
   typedef logic [`PIECE_WIDTH-1:0] piece_t;

   // square n at bits 4n+3:4n with square 0 at a1
   typedef logic [`BOARD_WIDTH-1:0] board_t;

   typedef logic [`POP_WIDTH-1:0] pop_t; // attack count from the move generator

   typedef logic signed [`SCORE_WIDTH-1:0] score_t; // centipawns with white positive

   typedef logic [`TALLY_WIDTH-1:0] tally_t;

   typedef struct packed
   {
      pop_t white_pop;
      pop_t black_pop;
   } mobility_t;

   typedef struct packed
   {
      logic   insufficient_material;
      score_t score;
   } eval_result_t;

   typedef enum logic [1:0]
   {
      idle,
      wait_attack,
      busy,
      done
   } eval_state_e;

endpackage

`default_nettype wire

/* rtl/eval_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module eval_sequencer import eval_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         board_valid,
   input  board_t       board_in,
   input  logic         is_attacking_done,
   input  logic         clear_eval,
   input  score_t       material,
   input  logic         insufficient,
   input  score_t       mobility,
   output board_t       board_q,
   output logic         eval_valid,
   output eval_result_t result
);

   eval_state_e  state;
   logic [1:0]   stage_cnt;
   eval_result_t next_result;

   // board follows the input while idle and freezes once a request is taken
   always_ff @(posedge clk)
   begin
      if (state == idle)
      begin
         board_q <= board_in;
      end
   end

   always_comb
   begin
      if (insufficient)
      begin
         next_result.insufficient_material = 1'b1;
         next_result.score = '0; // dead draw
      end
      else
      begin
         next_result.insufficient_material = 1'b0;
         next_result.score = material + mobility;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         stage_cnt <= '0;
         eval_valid <= 1'b0;
         result <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (board_valid)
               begin
                  state <= wait_attack;
               end
            end
            wait_attack:
            begin
               if (is_attacking_done)
               begin
                  state <= busy;
                  stage_cnt <= 2'(`BUSY_CYCLES - 1);
               end
            end
            busy:
            begin
               // material needs 3 cycles from the frozen board, mobility 2 from pops
               if (stage_cnt == 2'd0)
               begin
                  state <= done;
                  eval_valid <= 1'b1;
                  result <= next_result;
               end
               else
               begin
                  stage_cnt <= stage_cnt - 2'd1;
               end
            end
            done:
            begin
               if (clear_eval)
               begin
                  state <= idle;
                  eval_valid <= 1'b0;
               end
            end
            default:
            begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/eval_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module eval_top import eval_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         board_valid,
   input  board_t       board_in,
   input  logic         is_attacking_done,
   input  mobility_t    pops,
   input  logic         clear_eval,
   output logic         eval_valid,
   output eval_result_t result
);

   board_t board_q;
   score_t material;
   score_t mobility;
   logic   insufficient;

   eval_sequencer u_sequencer
   (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .is_attacking_done (is_attacking_done),
      .clear_eval        (clear_eval),
      .material          (material),
      .insufficient      (insufficient),
      .mobility          (mobility),
      .board_q           (board_q),
      .eval_valid        (eval_valid),
      .result            (result)
   );

   // the three pipelines run every clock and are picked up by the sequencer
   material_sum u_material_sum
   (
      .clk      (clk),
      .board_q  (board_q),
      .material (material)
   );

   material_guard u_material_guard
   (
      .clk          (clk),
      .board_q      (board_q),
      .insufficient (insufficient)
   );

   mobility_score u_mobility_score
   (
      .clk      (clk),
      .pops     (pops),
      .mobility (mobility)
   );

endmodule

`default_nettype wire

/* rtl/material_guard.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module material_guard import eval_pkg::*;
(
   input  logic   clk,
   input  board_t board_q,
   output logic   insufficient
);

   logic [1:0] white_class_q [`SQUARES];
   logic [1:0] black_class_q [`SQUARES];
   tally_t     white_tally;
   tally_t     black_tally;
   tally_t     white_tally_q;
   tally_t     black_tally_q;

   // a pawn, rook or queen alone can mate, so it weighs more than any pair of minors
   function automatic logic [1:0] piece_class(input piece_t piece, input logic black);
      logic [2:0] kind;
      kind = piece[2:0];
      if (piece[3] != black)
         return 2'd0;
      if (kind == `WHITE_PAWN || kind == `WHITE_ROOK || kind == `WHITE_QUEN)
         return 2'd3;
      if (kind == `WHITE_KNIT || kind == `WHITE_BISH)
         return 2'd1;
      return 2'd0; // king, empty, unused
   endfunction

   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         white_class_q[sq] <= piece_class(board_q[sq*`PIECE_WIDTH +: `PIECE_WIDTH], 1'b0);
         black_class_q[sq] <= piece_class(board_q[sq*`PIECE_WIDTH +: `PIECE_WIDTH], 1'b1);
      end
   end

   always_comb
   begin
      white_tally = '0;
      black_tally = '0;
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         white_tally = white_tally + tally_t'(white_class_q[sq]);
         black_tally = black_tally + tally_t'(black_class_q[sq]);
      end
   end

   always_ff @(posedge clk)
   begin
      white_tally_q <= white_tally;
      black_tally_q <= black_tally;
      // lone minor against a bare king cannot mate either way
      insufficient <= (white_tally_q == '0 && black_tally_q <= tally_t'(1)) ||
                      (white_tally_q <= tally_t'(1) && black_tally_q == '0);
   end

endmodule

`default_nettype wire

/* rtl/material_sum.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module material_sum import eval_pkg::*;
(
   input  logic   clk,
   input  board_t board_q,
   output score_t material
);

   score_t value_q    [`SQUARES];
   score_t rank_sum   [`RANKS];
   score_t rank_sum_q [`RANKS];
   score_t total;

   function automatic score_t piece_value(input piece_t piece);
      score_t value;
      case (piece)
         `WHITE_PAWN: value = score_t'(`VALUE_PAWN);
         `WHITE_KNIT: value = score_t'(`VALUE_KNIT);
         `WHITE_BISH: value = score_t'(`VALUE_BISH);
         `WHITE_ROOK: value = score_t'(`VALUE_ROOK);
         `WHITE_QUEN: value = score_t'(`VALUE_QUEN);
         `WHITE_KING: value = score_t'(`VALUE_KING);
         `BLACK_PAWN: value = -score_t'(`VALUE_PAWN);
         `BLACK_KNIT: value = -score_t'(`VALUE_KNIT);
         `BLACK_BISH: value = -score_t'(`VALUE_BISH);
         `BLACK_ROOK: value = -score_t'(`VALUE_ROOK);
         `BLACK_QUEN: value = -score_t'(`VALUE_QUEN);
         `BLACK_KING: value = -score_t'(`VALUE_KING);
         default:     value = '0; // empty and the unused codes
      endcase
      return value;
   endfunction

   // stage 1 maps every square to its signed value
   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         value_q[sq] <= piece_value(board_q[sq*`PIECE_WIDTH +: `PIECE_WIDTH]);
      end
   end

   always_comb
   begin
      for (int r = 0; r < `RANKS; r++)
      begin
         rank_sum[r] = '0;
         for (int f = 0; f < `FILES; f++)
         begin
            rank_sum[r] = rank_sum[r] + value_q[r*`FILES + f];
         end
      end
   end

   // stage 2 holds one sum per rank
   always_ff @(posedge clk)
   begin
      rank_sum_q <= rank_sum;
   end

   always_comb
   begin
      total = '0;
      for (int r = 0; r < `RANKS; r++)
      begin
         total = total + rank_sum_q[r];
      end
   end

   always_ff @(posedge clk)
   begin
      material <= total; // stage 3
   end

endmodule

`default_nettype wire

/* rtl/mobility_score.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module mobility_score import eval_pkg::*;
(
   input  logic      clk,
   input  mobility_t pops,
   output score_t    mobility
);

   mobility_t pops_q;
   score_t    white_term;
   score_t    black_term;

   always_ff @(posedge clk)
   begin
      pops_q <= pops; // stage 1
   end

   // the unsigned counts widen before the signed multiply
   always_comb
   begin
      white_term = score_t'(pops_q.white_pop) * score_t'(`POP_WEIGHT);
      black_term = score_t'(pops_q.black_pop) * score_t'(`POP_WEIGHT);
   end

   always_ff @(posedge clk)
   begin
      mobility <= white_term - black_term;
   end

endmodule

`default_nettype wire

/* verif/eval_tests.svh */
`ifndef EVAL_TESTS_SVH
`define EVAL_TESTS_SVH

function automatic board_t put_piece(input board_t board, input int sq, input piece_t piece);
   board_t b;
   b = board;
   b[sq*`PIECE_WIDTH +: `PIECE_WIDTH] = piece;
   return b;
endfunction

function automatic mobility_t pops_of(input int white, input int black);
   mobility_t p;
   p.white_pop = pop_t'(white);
   p.black_pop = pop_t'(black);
   return p;
endfunction

// white king on e1, black king on e8
function automatic board_t kings_only();
   return put_piece(put_piece('0, 4, `WHITE_KING), 60, `BLACK_KING);
endfunction

// one full request, latency and hold checks, then clear
task automatic evaluate_board(input string name, input board_t board, input mobility_t p,
                              input int delay, input int hold);
   eval_result_t expected;
   eval_result_t held;
   int           edges;
   expected = model_eval(board, p);
   @(posedge clk);
   board_in <= board;
   pops <= p;
   board_valid <= 1'b1;
   @(posedge clk);
   board_valid <= 1'b0;
   repeat (delay) @(posedge clk);
   is_attacking_done <= 1'b1;
   @(posedge clk); // DUT samples is_attacking_done here
   is_attacking_done <= 1'b0;
   edges = 0;
   do
   begin
      @(negedge clk);
      edges++;
   end
   while (!eval_valid && edges < 20);
   assert (eval_valid)
   else
   begin
      $display("%s: eval_valid did not rise within 20 cycles of is_attacking_done", name);
      errors++;
   end
   assert (edges == 5)
   else
   begin
      $display("[FAIL] %s latency: expected 5 edges, got %0d", name, edges);
      errors++;
   end
   assert (result == expected)
   else
   begin
      $display("[FAIL] %s: expected score %0d flag %0b, got score %0d flag %0b", name,
               expected.score, expected.insufficient_material,
               result.score, result.insufficient_material);
      errors++;
   end
   held = result;
   repeat (hold)
   begin
      @(negedge clk);
      assert (eval_valid && result == held)
      else
      begin
         $display("%s: result changed or eval_valid dropped before clear_eval", name);
         errors++;
      end
   end
   @(posedge clk);
   clear_eval <= 1'b1;
   @(posedge clk);
   clear_eval <= 1'b0;
   @(negedge clk);
   assert (!eval_valid)
   else
   begin
      $display("%s: eval_valid still high on the edge after clear_eval", name);
      errors++;
   end
endtask

task automatic idle_after_reset();
   repeat (10)
   begin
      @(negedge clk);
      assert (!eval_valid)
      else
      begin
         $display("eval_valid went high after reset with no request");
         errors++;
      end
      assert (result == '0)
      else
      begin
         $display("[FAIL] after reset: expected result 0, got %h", result);
         errors++;
      end
   end
endtask

task automatic material_balance();
   board_t heavy;
   board_t minor;
   heavy = put_piece(put_piece(kings_only(), 3, `WHITE_QUEN), 0, `WHITE_ROOK);
   heavy = put_piece(put_piece(heavy, 8, `WHITE_PAWN), 9, `WHITE_PAWN);
   heavy = put_piece(put_piece(heavy, 10, `WHITE_PAWN), 63, `BLACK_ROOK);
   heavy = put_piece(heavy, 48, `BLACK_PAWN);
   minor = put_piece(put_piece(kings_only(), 1, `WHITE_KNIT), 2, `WHITE_BISH);
   minor = put_piece(put_piece(minor, 6, `WHITE_KNIT), 61, `BLACK_BISH);
   minor = put_piece(minor, 62, `BLACK_KNIT);
   evaluate_board("material heavy", heavy, pops_of(20, 20), 1, 2);
   evaluate_board("material minor", minor, pops_of(33, 33), 1, 2);
endtask

task automatic mobility_shift();
   board_t board;
   board = put_piece(put_piece(kings_only(), 3, `WHITE_QUEN), 56, `BLACK_ROOK);
   evaluate_board("mobility 40 vs 12", board, pops_of(40, 12), 1, 2);
   evaluate_board("mobility 0 vs 63", board, pops_of(0, 63), 1, 2);
endtask

task automatic insufficient_material();
   evaluate_board("kings only", kings_only(), pops_of(30, 5), 1, 2);
   evaluate_board("king and knight", put_piece(kings_only(), 1, `WHITE_KNIT),
                  pops_of(12, 50), 1, 2);
   evaluate_board("king and bishop", put_piece(kings_only(), 61, `BLACK_BISH),
                  pops_of(63, 0), 1, 2);
   evaluate_board("king and pawn", put_piece(kings_only(), 12, `WHITE_PAWN),
                  pops_of(25, 17), 1, 2);
endtask

task automatic handshake_timing();
   board_t board;
   board = put_piece(put_piece(kings_only(), 27, `WHITE_BISH), 35, `BLACK_ROOK);
   evaluate_board("handshake delay 0", board, pops_of(9, 14), 0, 6);
   evaluate_board("handshake delay 3", board, pops_of(9, 14), 3, 6);
   evaluate_board("handshake delay 7", board, pops_of(9, 14), 7, 6);
endtask

task automatic random_boards();
   board_t board;
   int     pick;
   int     white;
   int     black;
   for (int n = 0; n < 10; n++)
   begin
      board = '0;
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         pick = $unsigned($random(seed)) % 13;
         if (pick > 6)
            pick = pick + 2; // skip the unused codes 7 and 8
         board = put_piece(board, sq, piece_t'(pick));
      end
      white = $unsigned($random(seed)) % 64;
      black = $unsigned($random(seed)) % 64;
      evaluate_board($sformatf("random board %0d", n), board, pops_of(white, black), n % 4, 1);
   end
endtask

`endif

/* verif/eval_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eval_config.svh"

module eval_tb import eval_pkg::*;
();

   localparam int REQUESTS = 22; // reset check plus every evaluated board
   localparam int WATCHDOG_CYCLES = 200 * REQUESTS + 100;

   logic         clk;
   logic         reset;
   logic         board_valid;
   board_t       board_in;
   logic         is_attacking_done;
   mobility_t    pops;
   logic         clear_eval;
   logic         eval_valid;
   eval_result_t result;

   int errors;
   int seed;

   tb_clock u_clock
   (
      .clk (clk)
   );

   eval_top DUT
   (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .is_attacking_done (is_attacking_done),
      .pops              (pops),
      .clear_eval        (clear_eval),
      .eval_valid        (eval_valid),
      .result            (result)
   );

   // reference score straight from the value table, class tally and mobility rule
   function automatic eval_result_t model_eval(input board_t board, input mobility_t p);
      int           material;
      int           white_tally;
      int           black_tally;
      int           value;
      int           weight;
      piece_t       piece;
      eval_result_t r;
      material = 0;
      white_tally = 0;
      black_tally = 0;
      for (int sq = 0; sq < `SQUARES; sq++)
      begin
         piece = board[sq*`PIECE_WIDTH +: `PIECE_WIDTH];
         case (piece[2:0])
            3'd1: value = `VALUE_PAWN;
            3'd2: value = `VALUE_KNIT;
            3'd3: value = `VALUE_BISH;
            3'd4: value = `VALUE_ROOK;
            3'd5: value = `VALUE_QUEN;
            3'd6: value = `VALUE_KING;
            default: value = 0; // empty, 7, 8, 15
         endcase
         case (piece[2:0])
            3'd1, 3'd4, 3'd5: weight = 3; // pawn, rook, queen
            3'd2, 3'd3: weight = 1;
            default: weight = 0;
         endcase
         if (piece[3])
         begin
            material = material - value;
            black_tally = black_tally + weight;
         end
         else
         begin
            material = material + value;
            white_tally = white_tally + weight;
         end
      end
      if ((white_tally == 0 && black_tally <= 1) || (white_tally <= 1 && black_tally == 0))
      begin
         r.insufficient_material = 1'b1;
         r.score = '0;
      end
      else
      begin
         r.insufficient_material = 1'b0;
         r.score = score_t'(material + `POP_WEIGHT * (int'(p.white_pop) - int'(p.black_pop)));
      end
      return r;
   endfunction

   `include "eval_tests.svh"

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog timeout after %0d cycles, a request never completed", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      errors = 0;
      seed = 32'hb456;
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      is_attacking_done = 1'b0;
      pops = '0;
      clear_eval = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      idle_after_reset();
      material_balance();
      mobility_shift();
      insufficient_material();
      handshake_timing();
      random_boards();

      $display("errors: %0d", errors);
      if (errors == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   always #50 clk = ~clk; // 100 ns period

endmodule

`default_nettype wire
